//--- flist.f
l15_bridge_pkg.sv
l15_req_fifo.sv
l15_bridge_ctrl.sv
l15_bridge.sv
tb_clk_gen.sv
l15_bridge_asserts.sv
tb_l15_bridge.sv

//--- Makefile
SIM     := verilator
FLAGS   := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP     := tb_l15_bridge
FLIST   := flist.f
OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SRCS    := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_l15_bridge.sv
module tb_l15_bridge;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_src      = l15_bridge_pkg::num_src;
  localparam int fifo_depth = 4;
  localparam int wait_limit = 20;

  // One bit per source index
  localparam logic [n_src-1:0] icache_mask = 2'b01;
  localparam logic [n_src-1:0] dcache_mask = 2'b10;
  localparam logic [n_src-1:0] both_mask   = 2'b11;

  logic                                   clk;
  logic                                   rst_n;
  l15_bridge_pkg::l15_req_t [n_src-1:0]   src_req;
  logic [n_src-1:0]                       src_req_v;
  logic [n_src-1:0]                       src_req_ready;
  l15_bridge_pkg::l15_req_t               l15_req;
  logic                                   l15_req_val;
  logic                                   l15_req_ack;
  l15_bridge_pkg::l15_ret_t               l15_ret;
  logic                                   l15_ret_val;
  l15_bridge_pkg::l15_ret_t               src_ret;
  logic [n_src-1:0]                       src_ret_v;
  logic [n_src-1:0]                       src_ret_ready;
  logic                                   l15_ret_ack;

  int errors;
  int timeouts;

  // Expected requests per engine in send order
  l15_bridge_pkg::l15_req_t icache_q [$];
  l15_bridge_pkg::l15_req_t dcache_q [$];

  tb_clk_gen u_clk_gen (.clk_o(clk));

  l15_bridge
    #(.fifo_els_p(fifo_depth))
    i_l15_bridge
    (.clk_i(clk)
     , .rst_n_i(rst_n)
     , .src_req_i(src_req)
     , .src_req_v_i(src_req_v)
     , .src_req_ready_o(src_req_ready)
     , .l15_req_o(l15_req)
     , .l15_req_val_o(l15_req_val)
     , .l15_req_ack_i(l15_req_ack)
     , .l15_ret_i(l15_ret)
     , .l15_ret_val_i(l15_ret_val)
     , .src_ret_o(src_ret)
     , .src_ret_v_o(src_ret_v)
     , .src_ret_ready_i(src_ret_ready)
     , .l15_ret_ack_o(l15_ret_ack)
     );

  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic flag_error(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  function automatic l15_bridge_pkg::l15_req_t random_req();
    l15_bridge_pkg::l15_req_t req;
    logic [63:0]              wide;
    wide         = {$urandom(), $urandom()};
    req.rqtype   = 5'($urandom());
    req.nc       = 1'($urandom());
    req.size     = 3'($urandom());
    req.address  = wide[l15_bridge_pkg::l15_addr_w-1:0];
    req.data     = {$urandom(), $urandom()};
    req.l1rplway = 2'($urandom());
    req.amo_op   = 4'($urandom());
    return req;
  endfunction

  function automatic l15_bridge_pkg::l15_ret_t random_ret(input l15_bridge_pkg::l15_rtntype_e t);
    l15_bridge_pkg::l15_ret_t ret;
    ret.rtntype              = t;
    ret.noncacheable         = 1'($urandom());
    ret.atomic               = 1'($urandom());
    ret.threadid             = 1'($urandom());
    ret.data_0               = {$urandom(), $urandom()};
    ret.data_1               = {$urandom(), $urandom()};
    ret.data_2               = {$urandom(), $urandom()};
    ret.data_3               = {$urandom(), $urandom()};
    ret.inval_address_15_4   = 12'($urandom());
    ret.inval_icache_inval   = 1'($urandom());
    ret.inval_dcache_inval   = 1'($urandom());
    ret.inval_icache_all_way = 1'($urandom());
    ret.inval_dcache_all_way = 1'($urandom());
    ret.inval_way            = 2'($urandom());
    return ret;
  endfunction

  // Fetch engine skips loads, stores and atomics and the data engine skips fills
  function automatic logic [n_src-1:0] expected_route(input l15_bridge_pkg::l15_rtntype_e t);
    logic [n_src-1:0] route;
    route = both_mask;
    case (t)
      l15_bridge_pkg::e_load_ret, l15_bridge_pkg::e_st_ack, l15_bridge_pkg::e_atomic_ret:
        route = dcache_mask;
      l15_bridge_pkg::e_ifill_ret:
        route = icache_mask;
      default:
        route = both_mask;
    endcase
    return route;
  endfunction

  task automatic wait_ready(input logic [n_src-1:0] mask);
    int n;
    n = 0;
    while (((src_req_ready & mask) != mask) && (n < wait_limit))
    begin
      step();
      n++;
    end
    if ((src_req_ready & mask) != mask)
    begin
      timeouts++;
      $display("Timeout: request queue not ready after %0d cycles", wait_limit);
    end
  endtask

  task automatic wait_req_val(output bit seen);
    int n;
    n = 0;
    while (!l15_req_val && (n < wait_limit))
    begin
      step();
      n++;
    end
    seen = l15_req_val;
    if (!seen)
    begin
      timeouts++;
      $display("Timeout: no request presented to the L1.5 within %0d cycles", wait_limit);
    end
  endtask

  task automatic enqueue(input logic [n_src-1:0] mask);
    l15_bridge_pkg::l15_req_t req;
    wait_ready(mask);
    for (int s = 0; s < n_src; s++)
    begin
      if (mask[s])
      begin
        req          = random_req();
        src_req[s]   = req;
        src_req_v[s] = 1'b1;
        if (s == l15_bridge_pkg::src_dcache)
          dcache_q.push_back(req);
        else
          icache_q.push_back(req);
      end
    end
    step();
    src_req_v = '0;
  endtask

  // With ack held high the data engine queue drains before the fetch engine queue
  task automatic drain_with_ack(input int n);
    l15_bridge_pkg::l15_req_t exp;
    bit                       seen;
    l15_req_ack = 1'b1;
    for (int k = 0; k < n; k++)
    begin
      wait_req_val(seen);
      if (!seen)
        break;
      if (dcache_q.size() > 0)
        exp = dcache_q.pop_front();
      else if (icache_q.size() > 0)
        exp = icache_q.pop_front();
      else
      begin
        flag_error("request presented with nothing outstanding");
        break;
      end
      if (l15_req !== exp)
        flag_error($sformatf("l15_req_o %h, expected %h", l15_req, exp));
      step();
    end
    l15_req_ack = 1'b0;
  endtask

  task automatic test_after_reset();
    step();
    if (l15_req_val !== 1'b0)
      flag_error("l15_req_val_o high after reset");
    if (src_ret_v !== '0)
      flag_error($sformatf("src_ret_v_o %b after reset", src_ret_v));
    if (l15_ret_ack !== 1'b0)
      flag_error("l15_ret_ack_o high after reset");
    if (src_req_ready !== both_mask)
      flag_error($sformatf("src_req_ready_o %b after reset", src_req_ready));
  endtask

  task automatic test_single_request();
    l15_bridge_pkg::l15_req_t sent;
    bit                       seen;
    enqueue(icache_mask);
    sent = icache_q[0];
    wait_req_val(seen);
    if (seen)
    begin
      // No ack yet so the packet must sit on the port
      for (int c = 0; c < 5; c++)
      begin
        if (!l15_req_val || (l15_req !== sent))
          flag_error($sformatf("held request %h, expected %h", l15_req, sent));
        step();
      end
    end
    l15_req_ack = 1'b1;
    step();
    l15_req_ack = 1'b0;
    icache_q.delete(0);
    if (l15_req_val !== 1'b0)
      flag_error("request still presented after its ack");
  endtask

  task automatic test_priority_order();
    for (int k = 0; k < 3; k++)
    begin
      enqueue(both_mask);
    end
    drain_with_ack(6);
    if ((l15_req_val !== 1'b0) || (icache_q.size() != 0) || (dcache_q.size() != 0))
      flag_error("requests left over after priority drain");
  endtask

  task automatic test_back_pressure();
    for (int k = 0; k < fifo_depth; k++)
    begin
      enqueue(icache_mask);
    end
    if (src_req_ready[l15_bridge_pkg::src_icache] !== 1'b0)
      flag_error("full fetch queue still ready");
    if (src_req_ready[l15_bridge_pkg::src_dcache] !== 1'b1)
      flag_error("idle data queue not ready");
    drain_with_ack(fifo_depth);
    if (src_req_ready[l15_bridge_pkg::src_icache] !== 1'b1)
      flag_error("fetch queue not ready after drain");
  endtask

  task automatic test_return_routing();
    l15_bridge_pkg::l15_rtntype_e types [6];
    l15_bridge_pkg::l15_ret_t     ret;
    logic [n_src-1:0]             exp_v;
    types = '{l15_bridge_pkg::e_load_ret, l15_bridge_pkg::e_ifill_ret,
              l15_bridge_pkg::e_evict_req, l15_bridge_pkg::e_st_ack,
              l15_bridge_pkg::e_int_ret, l15_bridge_pkg::e_atomic_ret};
    src_ret_ready = both_mask;
    foreach (types[k])
    begin
      ret         = random_ret(types[k]);
      exp_v       = expected_route(types[k]);
      l15_ret     = ret;
      l15_ret_val = 1'b1;
      #1;
      if (src_ret_v !== exp_v)
        flag_error($sformatf("type %0d src_ret_v_o %b, expected %b", types[k], src_ret_v, exp_v));
      if (src_ret !== ret)
        flag_error($sformatf("type %0d src_ret_o differs from l15_ret_i", types[k]));
      if (l15_ret_ack !== 1'b1)
        flag_error($sformatf("type %0d not acked with both engines ready", types[k]));
      step();
    end
    // Only destination not ready
    l15_ret       = random_ret(l15_bridge_pkg::e_ifill_ret);
    src_ret_ready = dcache_mask;
    #1;
    if (l15_ret_ack !== 1'b0)
      flag_error("ifill return acked while the fetch engine was not ready");
    step();
    l15_ret       = random_ret(l15_bridge_pkg::e_load_ret);
    src_ret_ready = icache_mask;
    #1;
    if (l15_ret_ack !== 1'b0)
      flag_error("load return acked while the data engine was not ready");
    step();
    l15_ret_val   = 1'b0;
    src_ret_ready = '0;
  endtask

  initial
  begin
    #1_000_000;
    $display("Simulation time limit reached before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    void'($urandom(48));
    errors        = 0;
    timeouts      = 0;
    rst_n         = 1'b0;
    src_req       = '0;
    src_req_v     = '0;
    l15_req_ack   = 1'b0;
    l15_ret       = '0;
    l15_ret_val   = 1'b0;
    src_ret_ready = '0;
    repeat (8) @(posedge clk);
    #10;
    rst_n = 1'b1;

    test_after_reset();
    test_single_request();
    test_priority_order();
    test_back_pressure();
    test_return_routing();

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if ((errors == 0) && (timeouts == 0))
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- l15_bridge_asserts.sv
module l15_bridge_asserts
  (input logic                                        clk_i
   , input logic                                      rst_n_i
   , input l15_bridge_pkg::l15_req_t                  l15_req_o
   , input logic                                      l15_req_val_o
   , input logic                                      l15_req_ack_i
   , input l15_bridge_pkg::l15_ret_t                  l15_ret_i
   , input logic [l15_bridge_pkg::num_src-1:0]        src_ret_v_o
   , input logic [l15_bridge_pkg::num_src-1:0]        src_req_v_i
   , input logic [l15_bridge_pkg::num_src-1:0]        src_req_ready_o
   );

  timeunit 1ns;
  timeprecision 1ps;

  // Presented request holds until the L1.5 acks it
  req_stable_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (l15_req_val_o && !l15_req_ack_i) |=> (l15_req_val_o && $stable(l15_req_o)))
    else $error("L1.5 request changed or dropped while waiting for ack");

  icache_route_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    src_ret_v_o[l15_bridge_pkg::src_icache] |->
      !((l15_ret_i.rtntype == l15_bridge_pkg::e_load_ret)
        || (l15_ret_i.rtntype == l15_bridge_pkg::e_st_ack)
        || (l15_ret_i.rtntype == l15_bridge_pkg::e_atomic_ret)))
    else $error("Fetch engine received a data-only return");

  dcache_route_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    src_ret_v_o[l15_bridge_pkg::src_dcache] |->
      (l15_ret_i.rtntype != l15_bridge_pkg::e_ifill_ret))
    else $error("Data engine received an instruction fill");

  // A queue only fills through enqueues
  for (genvar i = 0; i < l15_bridge_pkg::num_src; i++)
  begin : g_ready
    ready_fall_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $fell(src_req_ready_o[i]) |-> $past(src_req_v_i[i]))
      else $error("Request queue %0d lost ready without an enqueue", i);
  end

endmodule

bind l15_bridge l15_bridge_asserts u_asserts
  (.clk_i(clk_i)
   , .rst_n_i(rst_n_i)
   , .l15_req_o(l15_req_o)
   , .l15_req_val_o(l15_req_val_o)
   , .l15_req_ack_i(l15_req_ack_i)
   , .l15_ret_i(l15_ret_i)
   , .src_ret_v_o(src_ret_v_o)
   , .src_req_v_i(src_req_v_i)
   , .src_req_ready_o(src_req_ready_o)
   );

//--- tb_clk_gen.sv
module tb_clk_gen
  (output logic clk_o
   );

  timeunit 1ns;
  timeprecision 1ps;

  // 100 ns period
  initial
  begin
    clk_o = 1'b0;
  end

  always #50 clk_o = ~clk_o;

endmodule

//--- l15_bridge.sv
module l15_bridge
  #(parameter int fifo_els_p = 4)
  (input                                                           clk_i
   , input                                                         rst_n_i

   // Engine requests
   , input  l15_bridge_pkg::l15_req_t [l15_bridge_pkg::num_src-1:0] src_req_i
   , input  logic [l15_bridge_pkg::num_src-1:0]                    src_req_v_i
   , output logic [l15_bridge_pkg::num_src-1:0]                    src_req_ready_o

   // Bridge to L1.5
   , output l15_bridge_pkg::l15_req_t                              l15_req_o
   , output logic                                                  l15_req_val_o
   , input  logic                                                  l15_req_ack_i

   // L1.5 to bridge
   , input  l15_bridge_pkg::l15_ret_t                              l15_ret_i
   , input  logic                                                  l15_ret_val_i

   // Engine returns
   , output l15_bridge_pkg::l15_ret_t                              src_ret_o
   , output logic [l15_bridge_pkg::num_src-1:0]                    src_ret_v_o
   , input  logic [l15_bridge_pkg::num_src-1:0]                    src_ret_ready_i
   , output logic                                                  l15_ret_ack_o
   );

  l15_bridge_pkg::l15_req_t [l15_bridge_pkg::num_src-1:0] head;
  logic [l15_bridge_pkg::num_src-1:0]                    head_v;
  logic [l15_bridge_pkg::num_src-1:0]                    head_yumi;

  // One request queue per engine
  for (genvar i = 0; i < l15_bridge_pkg::num_src; i++)
  begin : g_src
    l15_req_fifo
      #(.fifo_els_p(fifo_els_p))
      u_req_fifo
      (.clk_i(clk_i)
       , .rst_n_i(rst_n_i)

       , .data_i(src_req_i[i])
       , .v_i(src_req_v_i[i])
       , .ready_o(src_req_ready_o[i])

       , .data_o(head[i])
       , .v_o(head_v[i])
       , .yumi_i(head_yumi[i])
       );
  end

  l15_bridge_ctrl
    u_ctrl
    (.head_i(head)
     , .head_v_i(head_v)
     , .head_yumi_o(head_yumi)

     , .l15_req_o(l15_req_o)
     , .l15_req_val_o(l15_req_val_o)
     , .l15_req_ack_i(l15_req_ack_i)

     , .l15_ret_val_i(l15_ret_val_i)
     , .l15_ret_rtntype_i(l15_ret_i.rtntype)

     , .src_ret_v_o(src_ret_v_o)
     , .src_ret_ready_i(src_ret_ready_i)
     , .l15_ret_ack_o(l15_ret_ack_o)
     );

  // Both engines see the same return payload, the valids pick the receiver
  assign src_ret_o = l15_ret_i;

endmodule

//--- l15_bridge_ctrl.sv
module l15_bridge_ctrl
  (// Queue heads, one per source
   input  l15_bridge_pkg::l15_req_t [l15_bridge_pkg::num_src-1:0] head_i
   , input  logic [l15_bridge_pkg::num_src-1:0]                    head_v_i
   , output logic [l15_bridge_pkg::num_src-1:0]                    head_yumi_o

   // Request port of the L1.5
   , output l15_bridge_pkg::l15_req_t                              l15_req_o
   , output logic                                                  l15_req_val_o
   , input  logic                                                  l15_req_ack_i

   // Return port of the L1.5
   , input  logic                                                  l15_ret_val_i
   , input  l15_bridge_pkg::l15_rtntype_e                          l15_ret_rtntype_i

   // Return valids toward the engines
   , output logic [l15_bridge_pkg::num_src-1:0]                    src_ret_v_o
   , input  logic [l15_bridge_pkg::num_src-1:0]                    src_ret_ready_i
   , output logic                                                  l15_ret_ack_o
   );

  logic [l15_bridge_pkg::num_src-1:0] grant;
  logic                               icache_takes;
  logic                               dcache_takes;

  // Fixed priority, highest index first so the data engine wins
  always_comb
  begin
    grant = '0;
    for (int i = l15_bridge_pkg::num_src - 1; i >= 0; i--)
    begin
      if (head_v_i[i] && (grant == '0))
      begin
        grant[i] = 1'b1;
      end
    end
  end

  // One-hot select of the granted head
  always_comb
  begin
    l15_req_o = '0;
    for (int i = 0; i < l15_bridge_pkg::num_src; i++)
    begin
      if (grant[i])
      begin
        l15_req_o = head_i[i];
      end
    end
  end

  assign l15_req_val_o = |grant;

  // Head leaves its queue on the acked cycle
  assign head_yumi_o = grant & {l15_bridge_pkg::num_src{l15_req_ack_i}};

  // Loads, stores and atomics belong to the data engine only
  assign icache_takes = !(l15_ret_rtntype_i inside {l15_bridge_pkg::e_load_ret,
                                                    l15_bridge_pkg::e_st_ack,
                                                    l15_bridge_pkg::e_atomic_ret});

  // Instruction fills belong to the fetch engine only
  assign dcache_takes = (l15_ret_rtntype_i != l15_bridge_pkg::e_ifill_ret);

  always_comb
  begin
    src_ret_v_o = '0;
    src_ret_v_o[l15_bridge_pkg::src_icache] = l15_ret_val_i & icache_takes;
    src_ret_v_o[l15_bridge_pkg::src_dcache] = l15_ret_val_i & dcache_takes;
  end

  // Return is consumed once any destination takes it
  assign l15_ret_ack_o = |(src_ret_v_o & src_ret_ready_i);

endmodule

//--- l15_req_fifo.sv
module l15_req_fifo
  #(parameter int fifo_els_p = 4)
  (input                              clk_i
   , input                            rst_n_i

   // Enqueue side
   , input  l15_bridge_pkg::l15_req_t data_i
   , input  logic                     v_i
   , output logic                     ready_o

   // Dequeue side
   , output l15_bridge_pkg::l15_req_t data_o
   , output logic                     v_o
   , input  logic                     yumi_i
   );

  localparam int ptr_w_lp = (fifo_els_p > 1) ? $clog2(fifo_els_p) : 1;
  localparam int cnt_w_lp = $clog2(fifo_els_p + 1);

  l15_bridge_pkg::l15_req_t mem_r [fifo_els_p];

  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [ptr_w_lp-1:0] rd_ptr_r;
  logic [cnt_w_lp-1:0] count_r;

  logic enq;
  logic deq;

  // Pointer advance with wrap, depth need not be a power of two
  function automatic logic [ptr_w_lp-1:0] ptr_inc(input logic [ptr_w_lp-1:0] ptr);
    logic [ptr_w_lp-1:0] nxt;
    if (ptr == ptr_w_lp'(fifo_els_p - 1))
      nxt = '0;
    else
      nxt = ptr + 1'b1;
    return nxt;
  endfunction

  assign ready_o = (count_r != cnt_w_lp'(fifo_els_p));
  assign v_o     = (count_r != '0);

  assign enq = v_i & ready_o;
  assign deq = yumi_i & v_o;

  // Head is read straight from storage
  assign data_o = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (enq)
      begin
        wr_ptr_r <= ptr_inc(wr_ptr_r);
      end

      if (deq)
      begin
        rd_ptr_r <= ptr_inc(rd_ptr_r);
      end

      // Occupancy holds when both sides move in the same cycle
      if (enq && !deq)
      begin
        count_r <= count_r + 1'b1;
      end
      else if (deq && !enq)
      begin
        count_r <= count_r - 1'b1;
      end
    end
  end

endmodule

//--- l15_bridge_pkg.sv
package l15_bridge_pkg;

  // L1.5 interface widths
  localparam int l15_addr_w  = 40;
  localparam int l15_dword_w = 64;

  // Request sources, the data engine has the higher index and wins arbitration
  localparam int num_src    = 2;
  localparam int src_icache = 0;
  localparam int src_dcache = 1;

  // Return types driven by the L1.5
  typedef enum logic [3:0]
  {
    e_load_ret   = 4'd0,
    e_ifill_ret  = 4'd1,
    e_evict_req  = 4'd3,
    e_st_ack     = 4'd4,
    e_int_ret    = 4'd7,
    e_atomic_ret = 4'd14
  } l15_rtntype_e;

  // One request toward the L1.5
  typedef struct packed
  {
    logic [4:0]             rqtype;
    logic                   nc;
    logic [2:0]             size;
    logic [l15_addr_w-1:0]  address;
    logic [l15_dword_w-1:0] data;
    // Way to replace in the L1 on a fill
    logic [1:0]             l1rplway;
    logic [3:0]             amo_op;
  } l15_req_t;

  // One return from the L1.5, shared by both engines
  typedef struct packed
  {
    l15_rtntype_e           rtntype;
    logic                   noncacheable;
    logic                   atomic;
    logic                   threadid;
    logic [l15_dword_w-1:0] data_0;
    logic [l15_dword_w-1:0] data_1;
    logic [l15_dword_w-1:0] data_2;
    logic [l15_dword_w-1:0] data_3;
    // Invalidation info, only meaningful on evict and ack returns
    logic [11:0]            inval_address_15_4;
    logic                   inval_icache_inval;
    logic                   inval_dcache_inval;
    logic                   inval_icache_all_way;
    logic                   inval_dcache_all_way;
    logic [1:0]             inval_way;
  } l15_ret_t;

endpackage
